//--- Makefile
# Verilator build and run of the link transmitter testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, search the log for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal -f project.f --top-module tb_link_tx \
		-o sim_link_tx
	./obj_dir/sim_link_tx | tee $(LOG)
	@grep -q "^Simulation finished: PASS$$" $(LOG) || \
		(echo "Pass line not found in $(LOG)" && exit 1)

clean:
	rm -rf obj_dir $(LOG)

//--- hdl/flit_queue.sv
// Two-entry queue of whole push flits; the head is held until head_ready
// push_ready looks at head_ready, so a full queue still takes a flit when its head leaves
`default_nettype none

module flit_queue #(
  parameter int push_width = link_pkg::push_width_default,
  parameter int pop_width = link_pkg::pop_width_default,
  parameter int metadata_width = link_pkg::metadata_width_default,
  localparam int ratio = push_width / pop_width,
  localparam int id_width = $clog2(ratio)
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      push_valid,
  output logic                      push_ready,
  input  logic [push_width-1:0]     push_data,
  input  logic                      push_last,
  input  logic [id_width-1:0]       push_dont_care_count,
  input  logic [metadata_width-1:0] push_metadata,
  output logic                      head_valid,
  input  logic                      head_ready,
  output logic [push_width-1:0]     head_data,
  output logic                      head_last,
  output logic [id_width-1:0]       head_dont_care_count,
  output logic [metadata_width-1:0] head_metadata
);

  // Flit storage, one slot per entry
  logic [push_width-1:0]     data_mem [2];
  logic                      last_mem [2];
  logic [id_width-1:0]       dcc_mem  [2];
  logic [metadata_width-1:0] meta_mem [2];

  logic       rd_ptr;
  logic       wr_ptr;
  logic [1:0] count;
  logic       push;
  logic       pop;

  assign head_valid = (count != 2'd0);
  // A slot frees up in the same cycle that the head is taken
  assign push_ready = (count != 2'd2) || head_ready;
  assign push = push_valid && push_ready;
  assign pop = head_valid && head_ready;

  assign head_data = data_mem[rd_ptr];
  assign head_last = last_mem[rd_ptr];
  assign head_dont_care_count = dcc_mem[rd_ptr];
  assign head_metadata = meta_mem[rd_ptr];

  // Payload slots carry no reset, only the pointers and count do
  always_ff @(posedge clk) begin
    if (push) begin
      data_mem[wr_ptr] <= push_data;
      last_mem[wr_ptr] <= push_last;
      dcc_mem[wr_ptr] <= push_dont_care_count;
      meta_mem[wr_ptr] <= push_metadata;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ptr <= 1'b0;
      wr_ptr <= 1'b0;
      count <= 2'd0;
    end else begin
      if (push) wr_ptr <= ~wr_ptr;
      if (pop) rd_ptr <= ~rd_ptr;
      // Push and pop together leave the fill level unchanged
      if (push && !pop) begin
        count <= count + 2'd1;
      end else if (pop && !push) begin
        count <= count - 2'd1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/flow_serializer.sv
// Cuts the stable head flit into pop flits, one per cycle, with no bubble between flits
// The head must not change until head_ready; msb_first must not change mid-flit
`default_nettype none

module flow_serializer #(
  parameter int push_width = link_pkg::push_width_default,
  parameter int pop_width = link_pkg::pop_width_default,
  parameter int metadata_width = link_pkg::metadata_width_default,
  localparam int ratio = push_width / pop_width,
  localparam int id_width = $clog2(ratio)
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      enable,
  input  logic                      msb_first,
  input  logic                      head_valid,
  output logic                      head_ready,
  input  logic [push_width-1:0]     head_data,
  input  logic                      head_last,
  input  logic [id_width-1:0]       head_dont_care_count,
  input  logic [metadata_width-1:0] head_metadata,
  output logic                      pop_valid,
  input  logic                      pop_ready,
  output logic [pop_width-1:0]      pop_data,
  output logic                      pop_last,
  output logic [metadata_width-1:0] pop_metadata
);

  // ----------------------------------------------------------------------
  // Slice counter
  // ----------------------------------------------------------------------

  localparam logic [id_width-1:0] last_id = id_width'(ratio - 1);

  logic [id_width-1:0] slice_cnt;
  logic [id_width-1:0] tail_cnt;
  logic [id_width-1:0] slice_id;
  logic                final_slice;
  logic                pop;

  assign pop = pop_valid && pop_ready;

  // Don't-care slices only shorten a flit that closes a packet
  assign tail_cnt = head_last ? head_dont_care_count : '0;
  assign final_slice = ((slice_cnt + tail_cnt) == last_id);

  // Counts pops within the current head and clears once the final one
  // is taken, so the next flit starts at slice 0 on the following cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      slice_cnt <= '0;
    end else if (pop) begin
      if (final_slice) begin
        slice_cnt <= '0;
      end else begin
        slice_cnt <= slice_cnt + 1'b1;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Slice select
  // ----------------------------------------------------------------------

  logic [pop_width-1:0] slices [ratio];

  // Slice k sits at bits [k*pop_width +: pop_width] of the head
  for (genvar k = 0; k < ratio; k++) begin : gen_slices
    assign slices[k] = head_data[k*pop_width +: pop_width];
  end

  // In msb-first order the counter walks the slices from the top down
  assign slice_id = msb_first ? (last_id - slice_cnt) : slice_cnt;
  assign pop_data = slices[slice_id];

  // ----------------------------------------------------------------------
  // Pop side and completion
  // ----------------------------------------------------------------------

  // Cut-through: the head shows on the pop side in the same cycle
  assign pop_valid = enable && head_valid;
  assign pop_last = head_last && final_slice;
  // Metadata rides along unchanged on every slice of its flit
  assign pop_metadata = head_metadata;

  // The head retires when its final slice is accepted, last flag or not
  assign head_ready = pop && final_slice;

endmodule

`default_nettype wire

//--- hdl/link_pkg.sv
// Shared widths and the APB register map of the link transmitter
// Every register is one 32-bit word, and offsets outside the map read as 0
`default_nettype none

package link_pkg;

  // ----------------------------------------------------------------------
  // Width defaults, picked up by the top level and passed down
  // ----------------------------------------------------------------------

  // Push width must be a multiple of the pop width, with a ratio of 2 or more
  parameter int push_width_default = 32;
  parameter int pop_width_default = 8;
  parameter int metadata_width_default = 3;

  // Both traffic counters wrap at this width
  parameter int count_width = 16;

  // ----------------------------------------------------------------------
  // Register offsets on the 8-bit APB address
  // ----------------------------------------------------------------------
  typedef enum logic [7:0] {
    // Bit 0 enable, bit 1 msb_first
    ctrl_addr         = 8'h00,
    // Bit 0 busy
    status_addr       = 8'h04,
    // Accepted pop flits
    flit_count_addr   = 8'h08,
    // Accepted pop flits that closed a packet
    packet_count_addr = 8'h0C
  } reg_addr_e;

endpackage

`default_nettype wire

//--- hdl/link_regs.sv
// APB slave with zero wait states; no pready or pslverr
// msb_first may only be written while busy reads 0, which is not checked here
`default_nettype none

module link_regs (
  input  logic        clk,
  input  logic        reset,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [7:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  input  logic        pop_valid,
  input  logic        pop_ready,
  input  logic        pop_last,
  input  logic        head_valid,
  output logic        enable,
  output logic        msb_first
);

  import link_pkg::*;

  // ----------------------------------------------------------------------
  // Address decode
  // ----------------------------------------------------------------------

  reg_addr_e addr;
  logic      wr_access;
  logic      rd_access;

  // Offsets that are not in the map fall through to the default arm
  assign addr = reg_addr_e'(paddr);

  // Writes land on the access phase of the transfer
  assign wr_access = psel && penable && pwrite;
  assign rd_access = psel && !pwrite;

  // ----------------------------------------------------------------------
  // Control register
  // ----------------------------------------------------------------------

  // Both bits come out of reset cleared, so the serializer starts stopped
  always_ff @(posedge clk) begin
    if (reset) begin
      enable <= 1'b0;
      msb_first <= 1'b0;
    end else if (wr_access && (addr == ctrl_addr)) begin
      enable <= pwdata[0];
      msb_first <= pwdata[1];
    end
  end

  // ----------------------------------------------------------------------
  // Traffic counters
  // ----------------------------------------------------------------------

  logic [count_width-1:0] flit_count;
  logic [count_width-1:0] packet_count;
  logic                   pop_taken;

  assign pop_taken = pop_valid && pop_ready;

  // Both counters wrap silently at their width
  always_ff @(posedge clk) begin
    if (reset) begin
      flit_count <= '0;
      packet_count <= '0;
    end else if (pop_taken) begin
      flit_count <= flit_count + 1'b1;
      // A packet is counted once, on the pop flit that carries pop_last
      if (pop_last) begin
        packet_count <= packet_count + 1'b1;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Read data mux
  // ----------------------------------------------------------------------

  // prdata is driven during both phases of a read and is 0 otherwise
  always_comb begin
    prdata = '0;
    if (rd_access) begin
      case (addr)
        ctrl_addr: begin
          prdata = {30'b0, msb_first, enable};
        end
        status_addr: begin
          // Busy while the queue still holds a flit
          prdata = {31'b0, head_valid};
        end
        flit_count_addr: begin
          prdata = 32'(flit_count);
        end
        packet_count_addr: begin
          prdata = 32'(packet_count);
        end
        default: begin
          prdata = '0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hdl/link_tx_top.sv
// Transmit side of the link: flit queue, serializer and APB register block
// Widths come from the package defaults; the push width must be a multiple of the pop width
`default_nettype none

module link_tx_top #(
  parameter int push_width = link_pkg::push_width_default,
  parameter int pop_width = link_pkg::pop_width_default,
  parameter int metadata_width = link_pkg::metadata_width_default,
  localparam int ratio = push_width / pop_width,
  localparam int id_width = $clog2(ratio)
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      push_valid,
  output logic                      push_ready,
  input  logic [push_width-1:0]     push_data,
  input  logic                      push_last,
  input  logic [id_width-1:0]       push_dont_care_count,
  input  logic [metadata_width-1:0] push_metadata,
  output logic                      pop_valid,
  input  logic                      pop_ready,
  output logic [pop_width-1:0]      pop_data,
  output logic                      pop_last,
  output logic [metadata_width-1:0] pop_metadata,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [7:0]                paddr,
  input  logic [31:0]               pwdata,
  output logic [31:0]               prdata
);

  // Head of the queue, held stable while the serializer scans it
  logic                      head_valid;
  logic                      head_ready;
  logic [push_width-1:0]     head_data;
  logic                      head_last;
  logic [id_width-1:0]       head_dont_care_count;
  logic [metadata_width-1:0] head_metadata;

  // Control bits from the register block
  logic enable;
  logic msb_first;

  flit_queue #(
    .push_width    (push_width),
    .pop_width     (pop_width),
    .metadata_width(metadata_width)
  ) queue_i (
    .clk                 (clk),
    .reset               (reset),
    .push_valid          (push_valid),
    .push_ready          (push_ready),
    .push_data           (push_data),
    .push_last           (push_last),
    .push_dont_care_count(push_dont_care_count),
    .push_metadata       (push_metadata),
    .head_valid          (head_valid),
    .head_ready          (head_ready),
    .head_data           (head_data),
    .head_last           (head_last),
    .head_dont_care_count(head_dont_care_count),
    .head_metadata       (head_metadata)
  );

  flow_serializer #(
    .push_width    (push_width),
    .pop_width     (pop_width),
    .metadata_width(metadata_width)
  ) serializer_i (
    .clk                 (clk),
    .reset               (reset),
    .enable              (enable),
    .msb_first           (msb_first),
    .head_valid          (head_valid),
    .head_ready          (head_ready),
    .head_data           (head_data),
    .head_last           (head_last),
    .head_dont_care_count(head_dont_care_count),
    .head_metadata       (head_metadata),
    .pop_valid           (pop_valid),
    .pop_ready           (pop_ready),
    .pop_data            (pop_data),
    .pop_last            (pop_last),
    .pop_metadata        (pop_metadata)
  );

  // The register block watches the pop handshake and the queue head
  link_regs regs_i (
    .clk       (clk),
    .reset     (reset),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pop_valid (pop_valid),
    .pop_ready (pop_ready),
    .pop_last  (pop_last),
    .head_valid(head_valid),
    .enable    (enable),
    .msb_first (msb_first)
  );

endmodule

`default_nettype wire

//--- project.f
hdl/link_pkg.sv
hdl/flit_queue.sv
hdl/flow_serializer.sv
hdl/link_regs.sv
hdl/link_tx_top.sv
testbench/link_tx_checker.sv
testbench/tb_link_tx.sv

//--- testbench/link_tx_checker.sv
// Scoreboard for the link transmitter; it sees only the top-level ports
// The slice order is captured at push time, so msb_first must not change while busy
`default_nettype none

module link_tx_checker #(
  parameter int push_width = link_pkg::push_width_default,
  parameter int pop_width = link_pkg::pop_width_default,
  parameter int metadata_width = link_pkg::metadata_width_default,
  localparam int ratio = push_width / pop_width,
  localparam int id_width = $clog2(ratio)
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      push_valid,
  input  logic                      push_ready,
  input  logic [push_width-1:0]     push_data,
  input  logic                      push_last,
  input  logic [id_width-1:0]       push_dont_care_count,
  input  logic [metadata_width-1:0] push_metadata,
  input  logic                      pop_valid,
  input  logic                      pop_ready,
  input  logic [pop_width-1:0]      pop_data,
  input  logic                      pop_last,
  input  logic [metadata_width-1:0] pop_metadata,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [7:0]                paddr,
  input  logic [31:0]               pwdata,
  input  logic [31:0]               prdata,
  output int                        error_count,
  output int                        pending
);
  timeunit 1ns;
  timeprecision 1ps;

  import link_pkg::*;

  localparam int count_mask = (1 << count_width) - 1;

  // ----------------------------------------------------------------------
  // Reference model state
  // ----------------------------------------------------------------------

  // One entry per expected pop flit, oldest first
  logic [pop_width-1:0]      exp_data  [$];
  logic                      exp_last  [$];
  logic [metadata_width-1:0] exp_meta  [$];
  logic                      exp_final [$];

  logic enable_m;
  logic msb_m;
  logic final_now;
  // Push flits accepted but not yet fully serialized
  int   outstanding;
  int   flit_tally;
  int   packet_tally;

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("ERROR at %0d ns: %s expected %0h, got %0h", $time, name, expected, actual);
      error_count++;
    end
  endtask

  // Slice k in send order; msb-first mirrors the slice index
  function automatic logic [pop_width-1:0] slice_of(input logic [push_width-1:0] data,
                                                    input int k, input logic msb);
    int idx;
    idx = msb ? (ratio - 1 - k) : k;
    return data[idx*pop_width +: pop_width];
  endfunction

  // A flit with its last flag set drops its don't-care tail slices
  task automatic expect_flit();
    int n;
    n = push_last ? (ratio - int'(push_dont_care_count)) : ratio;
    for (int k = 0; k < n; k++) begin
      exp_data.push_back(slice_of(push_data, k, msb_m));
      exp_last.push_back(push_last && (k == n - 1));
      exp_meta.push_back(push_metadata);
      exp_final.push_back(k == n - 1);
    end
    outstanding++;
  endtask

  task automatic check_pop();
    if (exp_data.size() == 0) begin
      $display("At %0d ns a pop flit was accepted while no pop flit was expected", $time);
      error_count++;
    end else begin
      check_value("pop_data", exp_data[0], pop_data);
      check_value("pop_last", exp_last[0], pop_last);
      check_value("pop_metadata", exp_meta[0], pop_metadata);
      if (exp_final[0]) outstanding--;
      void'(exp_data.pop_front());
      void'(exp_last.pop_front());
      void'(exp_meta.pop_front());
      void'(exp_final.pop_front());
    end
    flit_tally++;
    if (pop_last) packet_tally++;
  endtask

  // Register reads see the state from before this edge
  task automatic check_read();
    logic [31:0] expected;
    case (paddr)
      ctrl_addr:         expected = {30'b0, msb_m, enable_m};
      status_addr:       expected = {31'b0, outstanding != 0};
      flit_count_addr:   expected = flit_tally & count_mask;
      packet_count_addr: expected = packet_tally & count_mask;
      default:           expected = '0;
    endcase
    check_value($sformatf("prdata (addr %02h)", paddr), expected, prdata);
  endtask

  // ----------------------------------------------------------------------
  // Per-cycle comparison
  // ----------------------------------------------------------------------

  always @(posedge clk) begin
    if (reset) begin
      enable_m = 1'b0;
      msb_m = 1'b0;
      outstanding = 0;
      flit_tally = 0;
      packet_tally = 0;
      error_count = 0;
      exp_data.delete();
      exp_last.delete();
      exp_meta.delete();
      exp_final.delete();
    end else begin
      // A full queue still takes a push on the cycle its head retires
      final_now = pop_valid && pop_ready && exp_final.size() != 0 && exp_final[0];
      check_value("push_ready", (outstanding < 2) || final_now, push_ready);
      check_value("pop_valid", enable_m && (outstanding != 0), pop_valid);
      if (psel && penable && !pwrite) check_read();
      if (pop_valid && pop_ready) check_pop();
      if (push_valid && push_ready) expect_flit();
      if (psel && penable && pwrite && (paddr == ctrl_addr)) begin
        enable_m = pwdata[0];
        msb_m = pwdata[1];
      end
    end
    pending = exp_data.size();
  end

endmodule

`default_nettype wire

//--- testbench/tb_link_tx.sv
// Table-driven testbench for link_tx_top; all inputs change on the falling edge
// msb_first only changes while the DUT reads idle
`default_nettype none

module tb_link_tx;
  timeunit 1ns;
  timeprecision 1ps;

  import link_pkg::*;

  localparam int push_width = push_width_default;
  localparam int pop_width = pop_width_default;
  localparam int metadata_width = metadata_width_default;
  localparam int ratio = push_width / pop_width;
  localparam int id_width = $clog2(ratio);
  localparam int row_count = 13;
  localparam int group_count = 4;
  localparam int clk_period = 8;
  localparam logic [31:0] stall_seed = 32'h398ae669;

  // Each group is one test with its rows, its pop stall choice and its enable hold
  localparam int group_first [group_count] = '{0, 2, 4, 10};
  localparam int group_len   [group_count] = '{2, 2, 6, 3};
  localparam bit group_stall [group_count] = '{1'b0, 1'b0, 1'b1, 1'b0};
  localparam bit group_hold  [group_count] = '{1'b0, 1'b0, 1'b0, 1'b1};

  logic                      clk = 1'b0;
  logic                      reset;
  logic                      push_valid;
  logic                      push_ready;
  logic [push_width-1:0]     push_data;
  logic                      push_last;
  logic [id_width-1:0]       push_dont_care_count;
  logic [metadata_width-1:0] push_metadata;
  logic                      pop_valid;
  logic                      pop_ready;
  logic [pop_width-1:0]      pop_data;
  logic                      pop_last;
  logic [metadata_width-1:0] pop_metadata;
  logic                      psel;
  logic                      penable;
  logic                      pwrite;
  logic [7:0]                paddr;
  logic [31:0]               pwdata;
  logic [31:0]               prdata;

  int   error_count;
  int   pending;
  int   fail_count;
  logic random_stalls;

  // Stimulus table
  logic [push_width-1:0]     row_data [row_count];
  logic                      row_last [row_count];
  logic [id_width-1:0]       row_dcc  [row_count];
  logic [metadata_width-1:0] row_meta [row_count];
  logic                      row_msb  [row_count];

  link_tx_top #(
    .push_width    (push_width),
    .pop_width     (pop_width),
    .metadata_width(metadata_width)
  ) dut_i (
    .clk(clk), .reset(reset),
    .push_valid(push_valid), .push_ready(push_ready), .push_data(push_data),
    .push_last(push_last), .push_dont_care_count(push_dont_care_count),
    .push_metadata(push_metadata),
    .pop_valid(pop_valid), .pop_ready(pop_ready), .pop_data(pop_data),
    .pop_last(pop_last), .pop_metadata(pop_metadata),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
    .pwdata(pwdata), .prdata(prdata)
  );

  link_tx_checker #(
    .push_width    (push_width),
    .pop_width     (pop_width),
    .metadata_width(metadata_width)
  ) checker_i (
    .clk(clk), .reset(reset),
    .push_valid(push_valid), .push_ready(push_ready), .push_data(push_data),
    .push_last(push_last), .push_dont_care_count(push_dont_care_count),
    .push_metadata(push_metadata),
    .pop_valid(pop_valid), .pop_ready(pop_ready), .pop_data(pop_data),
    .pop_last(pop_last), .pop_metadata(pop_metadata),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
    .pwdata(pwdata), .prdata(prdata),
    .error_count(error_count), .pending(pending)
  );

  always #(clk_period / 2) clk = ~clk;

  // ----------------------------------------------------------------------
  // Stimulus table
  // ----------------------------------------------------------------------

  task automatic set_row(input int i, input logic [push_width-1:0] data, input logic last,
                         input logic [id_width-1:0] dcc, input logic [metadata_width-1:0] meta,
                         input logic msb);
    row_data[i] = data;
    row_last[i] = last;
    row_dcc[i] = dcc;
    row_meta[i] = meta;
    row_msb[i] = msb;
  endtask

  task automatic load_table();
    // Full flits with the lsb slice first
    set_row(0, 32'h44332211, 1'b0, 2'd0, 3'd5, 1'b0);
    set_row(1, 32'h88776655, 1'b0, 2'd0, 3'd2, 1'b0);
    // Msb first; the second row closes a packet with one don't-care slice
    set_row(2, 32'ha1b2c3d4, 1'b0, 2'd0, 3'd1, 1'b1);
    set_row(3, 32'h0badf00d, 1'b1, 2'd1, 3'd6, 1'b1);
    // Back-to-back under stalls; row 7 has a count that its clear last flag ignores
    set_row(4, 32'h12345678, 1'b0, 2'd0, 3'd0, 1'b0);
    set_row(5, 32'h9abcdef0, 1'b1, 2'd0, 3'd7, 1'b0);
    set_row(6, 32'hcafebabe, 1'b1, 2'd3, 3'd4, 1'b0);
    set_row(7, 32'h00ff00ff, 1'b0, 2'd2, 3'd3, 1'b0);
    set_row(8, 32'hdeadbeef, 1'b1, 2'd2, 3'd1, 1'b0);
    set_row(9, 32'h13579bdf, 1'b1, 2'd1, 3'd2, 1'b0);
    // Three flits pushed with the serializer stopped overfill the two-entry queue
    set_row(10, 32'h2468ace0, 1'b0, 2'd0, 3'd5, 1'b1);
    set_row(11, 32'hfedcba98, 1'b1, 2'd0, 3'd6, 1'b1);
    set_row(12, 32'h31415926, 1'b1, 2'd3, 3'd7, 1'b1);
  endtask

  // ----------------------------------------------------------------------
  // APB and push drivers
  // ----------------------------------------------------------------------

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    @(negedge clk);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = 1'b1;
    paddr = addr;
    pwdata = data;
    @(negedge clk);
    penable = 1'b1;
    @(negedge clk);
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
    @(negedge clk);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = addr;
    @(negedge clk);
    penable = 1'b1;
    @(posedge clk);
    data = prdata;
    @(negedge clk);
    psel = 1'b0;
    penable = 1'b0;
  endtask

  // Holds each row on the push port until the handshake edge
  task automatic push_rows(input int first, input int count);
    for (int i = first; i < first + count; i++) begin
      @(negedge clk);
      push_valid = 1'b1;
      push_data = row_data[i];
      push_last = row_last[i];
      push_dont_care_count = row_dcc[i];
      push_metadata = row_meta[i];
      @(posedge clk);
      while (!push_ready) @(posedge clk);
    end
    @(negedge clk);
    push_valid = 1'b0;
  endtask

  // Busy drops once the queue has no flit left
  task automatic wait_until_idle();
    logic [31:0] status;
    status = 32'd1;
    while (status[0]) read_reg(status_addr, status);
  endtask

  task automatic read_counters();
    logic [31:0] value;
    read_reg(flit_count_addr, value);
    read_reg(packet_count_addr, value);
  endtask

  task automatic run_group(input int g);
    int          first;
    logic        msb;
    logic [31:0] status;
    first = group_first[g];
    msb = row_msb[first];
    if (group_hold[g]) begin
      write_reg(ctrl_addr, {30'b0, msb, 1'b0});
      fork
        push_rows(first, group_len[g]);
        begin
          // The third push waits once both queue entries are taken
          @(negedge clk);
          while (push_ready) @(negedge clk);
          read_reg(status_addr, status);
          write_reg(ctrl_addr, {30'b0, msb, 1'b1});
        end
      join
    end else begin
      write_reg(ctrl_addr, {30'b0, msb, 1'b1});
      random_stalls = group_stall[g];
      push_rows(first, group_len[g]);
    end
    wait_until_idle();
    random_stalls = 1'b0;
    read_counters();
    if (pending != 0) begin
      $display("Test %0d ended with %0d pop flits that never came out", g + 1, pending);
      fail_count++;
    end
  endtask

  function automatic string group_name(input int g);
    case (g)
      0:       return "full flits, lsb slice first";
      1:       return "msb slice first with a don't-care tail";
      2:       return "back-to-back pushes under pop stalls";
      default: return "queue held with enable low, then drained";
    endcase
  endfunction

  task automatic report_test(input int num, input string name);
    $display("Test %0d (%s) done, errors so far: %0d", num, name, error_count + fail_count);
  endtask

  // ----------------------------------------------------------------------
  // Processes
  // ----------------------------------------------------------------------

  // Pop stalls hit about one cycle in four while a group asks for them
  initial begin
    void'($urandom(stall_seed));
    pop_ready = 1'b1;
    forever begin
      @(negedge clk);
      if (random_stalls) begin
        pop_ready = ($urandom % 4) != 0;
      end else begin
        pop_ready = 1'b1;
      end
    end
  end

  // Watchdog sized from the table length with margin for the APB traffic
  initial begin
    #((row_count * ratio + 200) * clk_period);
    $display("Watchdog expired: the DUT stopped making progress before the tests ended");
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    logic [31:0] value;
    push_valid = 1'b0;
    push_data = '0;
    push_last = 1'b0;
    push_dont_care_count = '0;
    push_metadata = '0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    random_stalls = 1'b0;
    fail_count = 0;
    load_table();
    reset = 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    for (int g = 0; g < group_count; g++) begin
      run_group(g);
      report_test(g + 1, group_name(g));
    end

    // Read back the control bits, two offsets outside the map and the counters
    read_reg(ctrl_addr, value);
    read_reg(8'h10, value);
    read_reg(8'hfc, value);
    read_counters();
    report_test(group_count + 1, "register readback and unmapped offsets");

    $display("Tests run: %0d, errors: %0d", group_count + 1, error_count + fail_count);
    if (error_count + fail_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
